/* Bender.yml */
package:
  name: systolic_ctrl

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/systolic_pkg.sv
      - design/instr_decoder.sv
      - design/tile_planner.sv
      - design/array_sequencer.sv
      - design/systolic_ctrl.sv
  - target: test
    include_dirs:
      - design
    files:
      - sim/tb_systolic_ctrl.sv

/* compile.f */
+incdir+design
design/systolic_pkg.sv
design/instr_decoder.sv
design/tile_planner.sv
design/array_sequencer.sv
design/systolic_ctrl.sv
sim/tb_systolic_ctrl.sv

/* design/array_sequencer.sv */
`include "systolic_macros.svh"

module array_sequencer (
    input  logic                     CLK,
    input  logic                     RST,
    input  systolic_pkg::layer_cfg_t i_cfg,
    input  logic                     i_exec_start,
    input  systolic_pkg::tile_t      i_tile,
    output logic                     o_start,
    output logic                     o_plan,
    output logic                     o_advance,
    output systolic_pkg::isram_req_t o_isram,
    output systolic_pkg::wsram_req_t o_wsram,
    output logic [`PE_COL-1:0]       o_psram_en,
    output logic [`PE_COL-1:0]       o_psram_wea,
    output logic [`BIT_ADDR-1:0]     o_psram_addr,
    output logic [`PE_COL-1:0]       o_psram_valid,
    output logic [`BIT_ROW_ID-1:0]   o_row_id,
    output logic [`PE_COL-1:0]       o_col_en,
    output logic                     o_finish
);
    import systolic_pkg::*;

    localparam logic [`BIT_DATA:0]   col_round = `PE_COL - 1;
    localparam logic [`BIT_DATA:0]   col_div   = `PE_COL;
    localparam logic [`BIT_DATA-1:0] ld_cycles = `PE_ROW;

    seq_state_e           state_q;
    logic [`BIT_DATA-1:0] cnt_q;

    logic                     start_q;
    logic                     plan_q;
    logic                     advance_q;
    isram_req_t               isram_q;
    wsram_req_t               wsram_q;
    logic [`PE_COL-1:0]       psram_en_q;
    logic [`PE_COL-1:0]       psram_wea_q;
    logic [`BIT_ADDR-1:0]     psram_addr_q;
    logic [`PE_COL-1:0]       psram_valid_q;
    logic [`BIT_ROW_ID-1:0]   row_id_q;
    logic [`PE_COL-1:0]       col_en_q;
    logic                     finish_q;

    logic [`BIT_DATA:0]       oc_blocks;
    logic [2*`BIT_DATA-1:0]   psum_rows;
    logic [`BIT_DATA-1:0]     ld_addr;
    logic [`BIT_DATA-1:0]     in_addr;
    logic [`BIT_DATA-1:0]     ps_addr;
    logic [`PE_ROW-1:0]       row_mask;
    logic [`PE_COL-1:0]       col_mask;

    // psum rows to clear: ceil(OC/PE_COL) * S
    assign oc_blocks = ({1'b0, i_cfg.oc} + col_round) / col_div;
    assign psum_rows = oc_blocks * i_cfg.s;

    assign ld_addr = i_tile.base_w + cnt_q;
    assign in_addr = i_tile.base_i + cnt_q;
    assign ps_addr = i_tile.psum_base + cnt_q;

    // thermometer masks, low bits set for the active rows and columns
    assign row_mask = ~({`PE_ROW{1'b1}} << i_tile.run_ic);
    assign col_mask = ~({`PE_COL{1'b1}} << i_tile.run_oc);

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state_q       <= ST_IDLE;
            cnt_q         <= '0;
            start_q       <= 1'b0;
            plan_q        <= 1'b0;
            advance_q     <= 1'b0;
            isram_q       <= '0;
            wsram_q       <= '0;
            psram_en_q    <= '0;
            psram_wea_q   <= '0;
            psram_addr_q  <= '0;
            psram_valid_q <= '0;
            row_id_q      <= '0;
            col_en_q      <= '0;
            finish_q      <= 1'b0;
        end else begin
            start_q   <= 1'b0;
            plan_q    <= 1'b0;
            advance_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (i_exec_start) begin
                        state_q  <= ST_INIT_PSUM;
                        cnt_q    <= '0;
                        start_q  <= 1'b1;
                        finish_q <= 1'b0;
                    end
                end
                ST_INIT_PSUM: begin
                    if ({{`BIT_DATA{1'b0}}, cnt_q} < psum_rows) begin
                        psram_en_q   <= '1;
                        psram_wea_q  <= '1;
                        psram_addr_q <= cnt_q[`BIT_ADDR-1:0];
                        cnt_q        <= cnt_q + 1'b1;
                    end else begin
                        psram_en_q   <= '0;
                        psram_wea_q  <= '0;
                        psram_addr_q <= '0;
                        cnt_q        <= '0;
                        plan_q       <= 1'b1;
                        state_q      <= ST_SET;
                    end
                end
                ST_SET: begin
                    // tile is registered by now, cursor may move on
                    advance_q <= 1'b1;
                    state_q   <= ST_LD;
                end
                ST_LD: begin
                    if (cnt_q < ld_cycles) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cnt_q < i_tile.run_ic) begin
                            wsram_q.en   <= col_mask;
                            wsram_q.addr <= ld_addr[`BIT_ADDR-1:0];
                            row_id_q     <= cnt_q[`BIT_ROW_ID-1:0];
                            col_en_q     <= col_mask;
                        end else begin
                            wsram_q  <= '0;
                            row_id_q <= '0;
                            col_en_q <= '0;
                        end
                    end else begin
                        cnt_q    <= '0;
                        wsram_q  <= '0;
                        row_id_q <= '0;
                        col_en_q <= '0;
                        state_q  <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (cnt_q < i_cfg.s) begin
                        cnt_q         <= cnt_q + 1'b1;
                        isram_q.en    <= row_mask;
                        isram_q.addr  <= in_addr[`BIT_ADDR-1:0];
                        psram_en_q    <= col_mask;
                        psram_valid_q <= col_mask;
                        psram_addr_q  <= ps_addr[`BIT_ADDR-1:0];
                    end else begin
                        cnt_q         <= '0;
                        isram_q       <= '0;
                        psram_en_q    <= '0;
                        psram_valid_q <= '0;
                        psram_addr_q  <= '0;
                        if (i_tile.last) begin
                            finish_q <= 1'b1;
                            state_q  <= ST_IDLE;
                        end else begin
                            plan_q  <= 1'b1;
                            state_q <= ST_SET;
                        end
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    assign o_start       = start_q;
    assign o_plan        = plan_q;
    assign o_advance     = advance_q;
    assign o_isram       = isram_q;
    assign o_wsram       = wsram_q;
    assign o_psram_en    = psram_en_q;
    assign o_psram_wea   = psram_wea_q;
    assign o_psram_addr  = psram_addr_q;
    assign o_psram_valid = psram_valid_q;
    assign o_row_id      = row_id_q;
    assign o_col_en      = col_en_q;
    assign o_finish      = finish_q;

endmodule

/* design/instr_decoder.sv */
`include "systolic_macros.svh"

module instr_decoder (
    input  logic                     CLK,
    input  logic                     RST,
    input  systolic_pkg::instr_t     i_instr,
    output systolic_pkg::layer_cfg_t o_cfg,
    output systolic_pkg::isram_req_t o_ld_isram,
    output systolic_pkg::wsram_req_t o_ld_wsram,
    output logic [`BIT_DATA-1:0]     o_data,
    output logic                     o_exec_start
);
    import systolic_pkg::*;

    layer_cfg_t           cfg_q;
    trg_e                 trg_q;
    isram_req_t           isram_q;
    wsram_req_t           wsram_q;
    logic [`BIT_DATA-1:0] data_q;
    logic                 exec_start_q;

    logic [`BIT_SEL-1:0]  bank;
    logic [`BIT_ADDR-1:0] addr;
    logic [`PE_ROW-1:0]   isram_hot;
    logic [`PE_COL-1:0]   wsram_hot;
    logic                 is_ldsram;

    // load field splits into bank index and address
    assign bank = i_instr.field[`BIT_PARAM-1 -: `BIT_SEL];
    assign addr = i_instr.field[`BIT_ADDR-1:0];

    // a bank past the last one shifts the bit out, so no strobe
    assign isram_hot = {{(`PE_ROW-1){1'b0}}, 1'b1} << bank;
    assign wsram_hot = {{(`PE_COL-1){1'b0}}, 1'b1} << bank;

    assign is_ldsram = i_instr.valid && (i_instr.opcode == OP_LDSRAM);

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            cfg_q        <= '0;
            trg_q        <= TRG_ISRAM;
            isram_q      <= '0;
            wsram_q      <= '0;
            exec_start_q <= 1'b0;
        end else begin
            exec_start_q <= 1'b0;
            if (i_instr.valid) begin
                // each valid instruction replaces the previous strobes
                isram_q <= '0;
                wsram_q <= '0;
                case (i_instr.opcode)
                    OP_PARAM: begin
                        case (param_sel_e'(i_instr.field))
                            SEL_S:   cfg_q.s  <= i_instr.data;
                            SEL_OC:  cfg_q.oc <= i_instr.data;
                            SEL_IC:  cfg_q.ic <= i_instr.data;
                            SEL_TRG: trg_q    <= trg_e'(i_instr.data);
                            default: ;
                        endcase
                    end
                    OP_LDSRAM: begin
                        // target picked by the last TRG write
                        if (trg_q == TRG_ISRAM) begin
                            isram_q.en   <= isram_hot;
                            isram_q.wea  <= isram_hot;
                            isram_q.addr <= addr;
                        end else if (trg_q == TRG_WSRAM) begin
                            wsram_q.en   <= wsram_hot;
                            wsram_q.wea  <= wsram_hot;
                            wsram_q.addr <= addr;
                        end
                    end
                    OP_EX: begin
                        exec_start_q <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // write data word for the SRAM load
    always_ff @(posedge CLK) begin
        if (is_ldsram) begin
            data_q <= i_instr.data;
        end
    end

    assign o_cfg        = cfg_q;
    assign o_ld_isram   = isram_q;
    assign o_ld_wsram   = wsram_q;
    assign o_data       = data_q;
    assign o_exec_start = exec_start_q;

endmodule

/* design/systolic_ctrl.sv */
`include "systolic_macros.svh"

module systolic_ctrl (
    input  logic                     CLK,
    input  logic                     RST,
    input  systolic_pkg::instr_t     i_instr,
    output logic [`BIT_DATA-1:0]     o_data,
    output systolic_pkg::isram_req_t o_isram,
    output systolic_pkg::wsram_req_t o_wsram,
    output logic [`PE_COL-1:0]       o_psram_en,
    output logic [`PE_COL-1:0]       o_psram_wea,
    output logic [`BIT_ADDR-1:0]     o_psram_addr,
    output logic [`PE_COL-1:0]       o_psram_valid,
    output logic [`BIT_ROW_ID-1:0]   o_row_id,
    output logic [`PE_COL-1:0]       o_col_en,
    output logic                     o_finish
);
    import systolic_pkg::*;

    layer_cfg_t cfg;
    isram_req_t dec_isram;
    wsram_req_t dec_wsram;
    isram_req_t seq_isram;
    wsram_req_t seq_wsram;
    tile_t      tile;
    logic       exec_start;
    logic       plan_start;
    logic       plan_tile;
    logic       plan_advance;

    instr_decoder u_decoder (
        .CLK          (CLK),
        .RST          (RST),
        .i_instr      (i_instr),
        .o_cfg        (cfg),
        .o_ld_isram   (dec_isram),
        .o_ld_wsram   (dec_wsram),
        .o_data       (o_data),
        .o_exec_start (exec_start)
    );

    tile_planner u_planner (
        .CLK       (CLK),
        .RST       (RST),
        .i_cfg     (cfg),
        .i_start   (plan_start),
        .i_plan    (plan_tile),
        .i_advance (plan_advance),
        .o_tile    (tile)
    );

    array_sequencer u_sequencer (
        .CLK           (CLK),
        .RST           (RST),
        .i_cfg         (cfg),
        .i_exec_start  (exec_start),
        .i_tile        (tile),
        .o_start       (plan_start),
        .o_plan        (plan_tile),
        .o_advance     (plan_advance),
        .o_isram       (seq_isram),
        .o_wsram       (seq_wsram),
        .o_psram_en    (o_psram_en),
        .o_psram_wea   (o_psram_wea),
        .o_psram_addr  (o_psram_addr),
        .o_psram_valid (o_psram_valid),
        .o_row_id      (o_row_id),
        .o_col_en      (o_col_en),
        .o_finish      (o_finish)
    );

    // loads and runs never overlap, so one side is always zero
    assign o_isram = dec_isram | seq_isram;
    assign o_wsram = dec_wsram | seq_wsram;

endmodule

/* design/systolic_macros.svh */
`ifndef SYSTOLIC_MACROS_SVH
`define SYSTOLIC_MACROS_SVH

// array shape
`define PE_ROW          8
`define PE_COL          4

// datapath and address widths
`define BIT_DATA        16
`define BIT_ADDR        12
`define BIT_SEL         4
`define BIT_PARAM       16
`define BIT_OPCODE      3
`define BIT_ROW_ID      4

// valid + opcode + field + data
`define BIT_INSTR       (1 + `BIT_OPCODE + `BIT_PARAM + `BIT_DATA)

// run sizes of one tile, wide enough for the full array dimension
`define BIT_RUN_IC      4
`define BIT_RUN_OC      3

// state register width of the sequencer
`define BIT_FSM         3

// opcodes
`define OPCODE_PARAM    3'd1
`define OPCODE_LDSRAM   3'd2
`define OPCODE_EX       3'd3

// parameter selectors carried in the field of a PARAM instruction
`define PARAM_S         16'd0
`define PARAM_OC        16'd1
`define PARAM_IC        16'd2
`define PARAM_TRG       16'd3

// load targets
`define TRG_ISRAM       16'd0
`define TRG_WSRAM       16'd1

`endif

/* design/systolic_pkg.sv */
`include "systolic_macros.svh"

package systolic_pkg;

    typedef enum logic [`BIT_OPCODE-1:0] {
        OP_PARAM  = `OPCODE_PARAM,
        OP_LDSRAM = `OPCODE_LDSRAM,
        OP_EX     = `OPCODE_EX
    } opcode_e;

    typedef enum logic [`BIT_PARAM-1:0] {
        SEL_S   = `PARAM_S,
        SEL_OC  = `PARAM_OC,
        SEL_IC  = `PARAM_IC,
        SEL_TRG = `PARAM_TRG
    } param_sel_e;

    typedef enum logic [`BIT_DATA-1:0] {
        TRG_ISRAM = `TRG_ISRAM,
        TRG_WSRAM = `TRG_WSRAM
    } trg_e;

    // field holds a selector, or the bank index above a 12-bit address
    typedef struct packed {
        logic                   valid;
        opcode_e                opcode;
        logic [`BIT_PARAM-1:0]  field;
        logic [`BIT_DATA-1:0]   data;
    } instr_t;

    typedef struct packed {
        logic [`BIT_DATA-1:0]   s;
        logic [`BIT_DATA-1:0]   oc;
        logic [`BIT_DATA-1:0]   ic;
    } layer_cfg_t;

    typedef struct packed {
        logic [`BIT_DATA-1:0]   base_i;
        logic [`BIT_DATA-1:0]   base_w;
        logic [`BIT_DATA-1:0]   psum_base;
        logic [`BIT_RUN_IC-1:0] run_ic;
        logic [`BIT_RUN_OC-1:0] run_oc;
        logic                   last;
    } tile_t;

    typedef struct packed {
        logic [`PE_ROW-1:0]     en;
        logic [`PE_ROW-1:0]     wea;
        logic [`BIT_ADDR-1:0]   addr;
    } isram_req_t;

    typedef struct packed {
        logic [`PE_COL-1:0]     en;
        logic [`PE_COL-1:0]     wea;
        logic [`BIT_ADDR-1:0]   addr;
    } wsram_req_t;

    typedef enum logic [`BIT_FSM-1:0] {
        ST_IDLE,
        ST_INIT_PSUM,
        ST_SET,
        ST_LD,
        ST_RUN
    } seq_state_e;

endpackage

/* design/tile_planner.sv */
`include "systolic_macros.svh"

module tile_planner (
    input  logic                     CLK,
    input  logic                     RST,
    input  systolic_pkg::layer_cfg_t i_cfg,
    input  logic                     i_start,
    input  logic                     i_plan,
    input  logic                     i_advance,
    output systolic_pkg::tile_t      o_tile
);
    import systolic_pkg::*;

    localparam logic [`BIT_DATA:0]     row_step    = `PE_ROW;
    localparam logic [`BIT_DATA:0]     col_step    = `PE_COL;
    localparam logic [`BIT_DATA-1:0]   row_div     = `PE_ROW;
    localparam logic [`BIT_DATA-1:0]   col_div     = `PE_COL;
    localparam logic [`BIT_RUN_IC-1:0] run_ic_full = `PE_ROW;
    localparam logic [`BIT_RUN_OC-1:0] run_oc_full = `PE_COL;

    // tile cursor, in channels
    logic [`BIT_DATA-1:0] state_ic;
    logic [`BIT_DATA-1:0] state_oc;

    // one extra bit so the step cannot wrap
    logic [`BIT_DATA:0]   ic_step;
    logic [`BIT_DATA:0]   oc_step;
    logic                 ic_edge;
    logic                 oc_edge;
    logic [`BIT_DATA-1:0] ic_blk;
    logic [`BIT_DATA-1:0] oc_blk;
    logic [`BIT_DATA-1:0] ic_rem;
    logic [`BIT_DATA-1:0] oc_rem;

    tile_t tile_d;
    tile_t tile_q;

    assign ic_step = {1'b0, state_ic} + row_step;
    assign oc_step = {1'b0, state_oc} + col_step;

    // edge tile when the next step reaches or passes the channel count
    assign ic_edge = ic_step >= {1'b0, i_cfg.ic};
    assign oc_edge = oc_step >= {1'b0, i_cfg.oc};

    assign ic_blk = state_ic / row_div;
    assign oc_blk = state_oc / col_div;
    assign ic_rem = i_cfg.ic - state_ic;
    assign oc_rem = i_cfg.oc - state_oc;

    always_comb begin
        tile_d.base_i    = i_cfg.s * ic_blk;
        tile_d.base_w    = state_ic + i_cfg.ic * oc_blk;
        tile_d.psum_base = oc_blk * i_cfg.s;
        tile_d.run_ic    = ic_edge ? ic_rem[`BIT_RUN_IC-1:0] : run_ic_full;
        tile_d.run_oc    = oc_edge ? oc_rem[`BIT_RUN_OC-1:0] : run_oc_full;
        tile_d.last      = ic_edge && oc_edge;
    end

    // IC is the inner loop, OC the outer
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state_ic <= '0;
            state_oc <= '0;
        end else if (i_start) begin
            state_ic <= '0;
            state_oc <= '0;
        end else if (i_advance) begin
            if (ic_edge) begin
                state_ic <= '0;
                state_oc <= oc_step[`BIT_DATA-1:0];
            end else begin
                state_ic <= ic_step[`BIT_DATA-1:0];
            end
        end
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            tile_q <= '0;
        end else if (i_plan) begin
            tile_q <= tile_d;
        end
    end

    assign o_tile = tile_q;

endmodule

/* sim/tb_systolic_ctrl.sv */
`include "systolic_macros.svh"

module tb_systolic_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    import systolic_pkg::*;

    localparam int NUM_CFG = 7;

    // one expected weight row load
    typedef struct packed {
        logic [7:0]                tile;
        logic [`BIT_ADDR-1:0]      addr;
        logic [`BIT_ROW_ID-1:0]    row_id;
        logic [`PE_COL-1:0]        mask;
    } ld_req_t;

    // one streaming cycle with input read and psum address
    typedef struct packed {
        logic [7:0]                tile;
        logic [`BIT_ADDR-1:0]      i_addr;
        logic [`PE_ROW-1:0]        i_mask;
        logic [`BIT_ADDR-1:0]      p_addr;
        logic [`PE_COL-1:0]        p_mask;
    } run_req_t;

    logic                   CLK = 1'b0;
    logic                   RST;
    instr_t                 i_instr;
    logic [`BIT_DATA-1:0]   data;
    isram_req_t             isram;
    wsram_req_t             wsram;
    logic [`PE_COL-1:0]     psram_en;
    logic [`PE_COL-1:0]     psram_wea;
    logic [`BIT_ADDR-1:0]   psram_addr;
    logic [`PE_COL-1:0]     psram_valid;
    logic [`BIT_ROW_ID-1:0] row_id;
    logic [`PE_COL-1:0]     col_en;
    logic                   finish;

    logic [`BIT_ADDR-1:0] init_q[$];
    ld_req_t              ld_q[$];
    run_req_t             run_q[$];

    logic quiet_phase = 1'b1;
    logic exec_active = 1'b0;
    logic finish_prev = 1'b0;
    int   finish_rises = 0;
    int   errors = 0;
    int   watchdog_ns = 0;

    systolic_ctrl UUT (
        .CLK           (CLK),
        .RST           (RST),
        .i_instr       (i_instr),
        .o_data        (data),
        .o_isram       (isram),
        .o_wsram       (wsram),
        .o_psram_en    (psram_en),
        .o_psram_wea   (psram_wea),
        .o_psram_addr  (psram_addr),
        .o_psram_valid (psram_valid),
        .o_row_id      (row_id),
        .o_col_en      (col_en),
        .o_finish      (finish)
    );

    always #10 CLK = ~CLK;

    task automatic stop_on_error();
        errors++;
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        stop_on_error();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    // drive one instruction for a single cycle
    task automatic issue(input opcode_e op, input logic [`BIT_PARAM-1:0] field,
                         input logic [`BIT_DATA-1:0] wdata);
        @(negedge CLK);
        i_instr.valid  = 1'b1;
        i_instr.opcode = op;
        i_instr.field  = field;
        i_instr.data   = wdata;
        @(negedge CLK);
        i_instr = '0;
    endtask

    // queue the requests of one run with IC inner and OC outer
    task automatic build_model(input int s, input int ic, input int oc);
        int      tile;
        int      run_ic;
        int      run_oc;
        ld_req_t ld;
        run_req_t rq;
        init_q.delete();
        ld_q.delete();
        run_q.delete();
        for (int a = 0; a < ((oc + `PE_COL - 1) / `PE_COL) * s; a++) begin
            init_q.push_back(`BIT_ADDR'(a));
        end
        tile = 0;
        for (int oc0 = 0; oc0 < oc; oc0 += `PE_COL) begin
            for (int ic0 = 0; ic0 < ic; ic0 += `PE_ROW) begin
                run_ic = (ic - ic0 < `PE_ROW) ? ic - ic0 : `PE_ROW;
                run_oc = (oc - oc0 < `PE_COL) ? oc - oc0 : `PE_COL;
                for (int k = 0; k < run_ic; k++) begin
                    ld.tile   = 8'(tile);
                    ld.addr   = `BIT_ADDR'(ic0 + ic * (oc0 / `PE_COL) + k);
                    ld.row_id = `BIT_ROW_ID'(k);
                    ld.mask   = `PE_COL'((1 << run_oc) - 1);
                    ld_q.push_back(ld);
                end
                for (int k = 0; k < s; k++) begin
                    rq.tile   = 8'(tile);
                    rq.i_addr = `BIT_ADDR'(s * (ic0 / `PE_ROW) + k);
                    rq.i_mask = `PE_ROW'((1 << run_ic) - 1);
                    rq.p_addr = `BIT_ADDR'((oc0 / `PE_COL) * s + k);
                    rq.p_mask = `PE_COL'((1 << run_oc) - 1);
                    run_q.push_back(rq);
                end
                tile++;
            end
        end
    endtask

    function automatic int run_cycles(input int s, input int ic, input int oc);
        int oc_blk;
        int tiles;
        oc_blk = (oc + `PE_COL - 1) / `PE_COL;
        tiles  = ((ic + `PE_ROW - 1) / `PE_ROW) * oc_blk;
        return 16 + oc_blk * s + tiles * (s + `PE_ROW + 4);
    endfunction

    // one LDSRAM with random address and data that must hold for two cycles
    task automatic load_bank(input logic to_wsram, input int bank);
        logic [`BIT_ADDR-1:0] addr;
        logic [`BIT_DATA-1:0] wdata;
        logic [`PE_ROW-1:0]   exp_i;
        logic [`PE_COL-1:0]   exp_w;
        addr  = `BIT_ADDR'($urandom);
        wdata = `BIT_DATA'($urandom);
        exp_i = '0;
        exp_w = '0;
        if (!to_wsram && bank < `PE_ROW) exp_i[bank] = 1'b1;
        if (to_wsram && bank < `PE_COL) exp_w[bank] = 1'b1;
        issue(OP_LDSRAM, {`BIT_SEL'(bank), addr}, wdata);
        repeat (2) begin
            check_value("o_isram.en", isram.en, exp_i);
            check_value("o_isram.wea", isram.wea, exp_i);
            check_value("o_wsram.en", wsram.en, exp_w);
            check_value("o_wsram.wea", wsram.wea, exp_w);
            if (exp_i != 0) check_value("o_isram.addr", isram.addr, addr);
            if (exp_w != 0) check_value("o_wsram.addr", wsram.addr, addr);
            check_value("o_data", data, wdata);
            @(negedge CLK);
        end
    endtask

    task automatic run_layer(input int s, input int ic, input int oc);
        int rises_before;
        issue(OP_PARAM, SEL_S, `BIT_DATA'(s));
        issue(OP_PARAM, SEL_IC, `BIT_DATA'(ic));
        issue(OP_PARAM, SEL_OC, `BIT_DATA'(oc));
        build_model(s, ic, oc);
        rises_before = finish_rises;
        exec_active = 1'b1;
        issue(OP_EX, '0, '0);
        while (finish_rises == rises_before) @(negedge CLK);
        exec_active = 1'b0;
        repeat (3) @(negedge CLK);
        // finish level holds until the next start
        check_value("o_finish", finish, 1);
        check_value("finish rises per EX", finish_rises - rises_before, 1);
    endtask

    always @(negedge CLK) begin : output_checker
        ld_req_t  ld;
        run_req_t rq;
        if (quiet_phase) begin
            check_value("o_isram.en", isram.en, 0);
            check_value("o_isram.wea", isram.wea, 0);
            check_value("o_wsram.en", wsram.en, 0);
            check_value("o_wsram.wea", wsram.wea, 0);
            check_value("o_finish", finish, 0);
        end
        if (!exec_active) begin
            check_value("o_psram_en", psram_en, 0);
            check_value("o_psram_wea", psram_wea, 0);
            check_value("o_psram_valid", psram_valid, 0);
            check_value("o_row_id", row_id, 0);
            check_value("o_col_en", col_en, 0);
        end else begin
            check_value("o_isram.wea", isram.wea, 0);
            check_value("o_wsram.wea", wsram.wea, 0);
            // psum clear
            if (psram_wea != 0) begin
                if (init_q.size() == 0) report_failure("psram write after the psum clear ended");
                check_value("o_psram_en", psram_en, {`PE_COL{1'b1}});
                check_value("o_psram_wea", psram_wea, {`PE_COL{1'b1}});
                check_value("o_psram_valid", psram_valid, 0);
                check_value("o_psram_addr", psram_addr, init_q.pop_front());
            end
            // weight rows
            if (wsram.en != 0) begin
                if (ld_q.size() == 0) report_failure("wsram read with no weight row expected");
                if (init_q.size() != 0) report_failure("weight load began during the psum clear");
                ld = ld_q.pop_front();
                if (run_q.size() != 0 && run_q[0].tile < ld.tile)
                    report_failure("weight load began before the previous tile finished");
                check_value("o_wsram.addr", wsram.addr, ld.addr);
                check_value("o_wsram.en", wsram.en, ld.mask);
                check_value("o_row_id", row_id, ld.row_id);
                check_value("o_col_en", col_en, ld.mask);
            end else begin
                check_value("o_row_id", row_id, 0);
                check_value("o_col_en", col_en, 0);
            end
            // input streaming
            if (isram.en != 0) begin
                if (run_q.size() == 0) report_failure("isram read with no input expected");
                rq = run_q.pop_front();
                if (ld_q.size() != 0 && ld_q[0].tile <= rq.tile)
                    report_failure("input stream began before its weights were loaded");
                check_value("o_isram.addr", isram.addr, rq.i_addr);
                check_value("o_isram.en", isram.en, rq.i_mask);
                check_value("o_psram_addr", psram_addr, rq.p_addr);
                check_value("o_psram_en", psram_en, rq.p_mask);
                check_value("o_psram_valid", psram_valid, rq.p_mask);
            end else if (psram_wea == 0) begin
                check_value("o_psram_en", psram_en, 0);
                check_value("o_psram_valid", psram_valid, 0);
            end
        end
        if (finish && !finish_prev) begin
            if (!exec_active) report_failure("o_finish rose with no run in progress");
            if (init_q.size() + ld_q.size() + run_q.size() != 0)
                report_failure("o_finish rose before all expected requests were seen");
            finish_rises++;
        end
        finish_prev = finish;
    end

    initial begin : watchdog
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("run did not end within %0d ns", watchdog_ns);
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    end

    initial begin : stimulus
        int total;
        int cfg_s[NUM_CFG];
        int cfg_ic[NUM_CFG];
        int cfg_oc[NUM_CFG];
        void'($urandom(16));
        RST     = 1'b1;
        i_instr = '0;

        // exact fit, single edge tile, then multi-tile with edges on both axes
        cfg_s[0] = 3;
        cfg_ic[0] = 8;
        cfg_oc[0] = 4;
        cfg_s[1] = 2;
        cfg_ic[1] = 5;
        cfg_oc[1] = 3;
        cfg_s[2] = 4;
        cfg_ic[2] = 17;
        cfg_oc[2] = 9;
        for (int i = 3; i < NUM_CFG; i++) begin
            cfg_s[i]  = 1 + ($urandom % 6);
            cfg_ic[i] = 1 + ($urandom % 20);
            cfg_oc[i] = 1 + ($urandom % 12);
        end
        total = 200;
        for (int i = 0; i < NUM_CFG; i++) begin
            total += run_cycles(cfg_s[i], cfg_ic[i], cfg_oc[i]);
        end
        watchdog_ns = total * 20 * 2;

        repeat (5) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
        repeat (3) @(negedge CLK);
        quiet_phase = 1'b0;

        issue(OP_PARAM, SEL_TRG, TRG_ISRAM);
        for (int b = 0; b < `PE_ROW; b++) load_bank(1'b0, b);
        load_bank(1'b0, `PE_ROW);
        load_bank(1'b0, 15);
        // end on a live strobe so the next PARAM has something to clear
        load_bank(1'b0, int'($urandom % `PE_ROW));
        issue(OP_PARAM, SEL_TRG, TRG_WSRAM);
        check_value("o_isram.en", isram.en, 0);
        check_value("o_isram.wea", isram.wea, 0);
        for (int b = 0; b < `PE_COL; b++) load_bank(1'b1, b);
        load_bank(1'b1, `PE_COL);
        load_bank(1'b1, 15);
        load_bank(1'b1, int'($urandom % `PE_COL));
        issue(OP_PARAM, SEL_S, `BIT_DATA'(1));
        check_value("o_wsram.en", wsram.en, 0);
        check_value("o_wsram.wea", wsram.wea, 0);
        check_value("o_isram.en", isram.en, 0);

        for (int i = 0; i < NUM_CFG; i++) begin
            run_layer(cfg_s[i], cfg_ic[i], cfg_oc[i]);
        end

        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "run ended with errors");
        end
    end

endmodule
